// ==== all.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/wall_pkg.sv
hdl/wall_if.sv
hdl/host_port.sv
hdl/vga_sync.sv
hdl/row_table.sv
hdl/row_render.sv
hdl/pixel_out.sv
hdl/raycast_top.sv
bench/tb_raycast_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_raycast_top
FILELIST  := all.f
BUILD_DIR := obj_dir

SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_raycast_top.sv ====
`timescale 1ns/1ps
`include "rbz_config.svh"

module tb_raycast_top;
  localparam int WAIT_LIMIT = 2 * `RBZ_H_TOTAL * `RBZ_V_TOTAL;  // Two frames

  logic       clk;
  logic       i_reset;
  logic       i_sclk;
  logic       i_mosi;
  logic       i_ss_n;
  logic       o_hsync_n;
  logic       o_vsync_n;
  logic [5:0] o_rgb;
  logic [9:0] o_hpos;
  logic [9:0] o_vpos;

  // Model of the row table where unwritten rows keep wall 0
  logic [511:0][1:0] m_wall;
  logic [511:0]      m_side;
  logic [511:0][9:0] m_size;
  logic [511:0][5:0] m_texu;
  logic [511:0][7:0] m_texa;

  // Slot 0 bg_left and slot 1 bg_right with {wall, texel} for walls 1..3
  logic [7:0][5:0] pend_col;   // Written by the host
  logic [7:0][5:0] shown_col;  // In use for the current frame
  logic [15:0]     lfsr_q;

  raycast_top u_dut (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_sclk    (i_sclk),
    .i_mosi    (i_mosi),
    .i_ss_n    (i_ss_n),
    .o_hsync_n (o_hsync_n),
    .o_vsync_n (o_vsync_n),
    .o_rgb     (o_rgb),
    .o_hpos    (o_hpos),
    .o_vpos    (o_vpos)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  // Style swap in blanking after the last visible pixel
  always @(posedge clk) begin
    if (i_reset || (o_hpos == 10'd799 && o_vpos == 10'd479)) begin
      shown_col <= pend_col;
    end
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_stop($sformatf("[FAIL] %s: expected %0h actual %0h", test_name, expected, actual));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // One step per bit
      v = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // Pixel colour from the span, checker and shading rules
  function automatic logic [5:0] expect_pixel(input int h, input int v);
    logic [8:0] r;
    logic [2:0] ci;
    logic [5:0] c;
    int         half;
    int         start;
    int         stop;
    int         acc;
    int         texv;
    int         texel;
    if (h >= `RBZ_H_VIEW || v >= `RBZ_V_VIEW) begin
      return 6'd0;  // Blanking is black
    end
    r     = v[8:0];
    half  = int'(m_size[r]) / 2;
    start = (half >= `RBZ_HALF_SIZE) ? 0 : `RBZ_HALF_SIZE - half;
    stop  = start + int'(m_size[r]);
    if (stop > `RBZ_H_VIEW) begin
      stop = `RBZ_H_VIEW;
    end
    if (m_wall[r] != 2'd0 && h >= start && h < stop) begin
      acc   = ((h - start) * int'(m_texa[r])) % 16384;  // Step sum before this pixel
      texv  = (acc / 256) % 64;
      texel = int'(m_texu[r][3]) ^ ((texv / 8) % 2);
      ci    = 3'(2 * int'(m_wall[r]) + texel);
      c     = shown_col[ci];
      if (m_side[r]) begin
        c = c & 6'b101010;  // Shaded face
      end
      return c;
    end
    return (h < `RBZ_HALF_SIZE) ? shown_col[0] : shown_col[1];
  endfunction

  task automatic wait_pos(input int h, input int v);
    int n;
    n = 0;
    @(negedge clk);
    while (int'(o_hpos) != h || int'(o_vpos) != v) begin
      if (n >= WAIT_LIMIT) begin
        fail_stop($sformatf("Timed out waiting for column %0d of row %0d", h, v));
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  // Mode 0, MSB first, 4 clocks per half period
  task automatic send_frame(input logic [39:0] word, input int nbits);
    logic [39:0] sh;
    sh = word;
    @(posedge clk);
    i_ss_n <= 1'b0;
    for (int i = 0; i < nbits; i++) begin
      i_mosi <= sh[39];
      sh = sh << 1;  // Bits past 40 go out as 0
      repeat (4) @(posedge clk);
      i_sclk <= 1'b1;
      repeat (4) @(posedge clk);
      i_sclk <= 1'b0;
    end
    repeat (4) @(posedge clk);
    i_ss_n <= 1'b1;
    repeat (12) @(posedge clk);  // Decode and table write
  endtask

  function automatic logic [39:0] record_word(input logic [8:0] row, input logic [1:0] wall,
      input logic side, input logic [9:0] size, input logic [5:0] texu, input logic [7:0] texa);
    return {1'b0, row, wall, side, size, texu, texa, 3'b000};  // Kind 0
  endfunction

  task automatic write_record(input logic [8:0] row, input logic [1:0] wall, input logic side,
                              input logic [9:0] size, input logic [5:0] texu,
                              input logic [7:0] texa);
    send_frame(record_word(row, wall, side, size, texu, texa), 40);
    m_wall[row] = wall;
    m_side[row] = side;
    m_size[row] = size;
    m_texu[row] = texu;
    m_texa[row] = texa;
  endtask

  task automatic write_style(input logic [2:0] addr, input logic [11:0] data);
    logic [2:0] w;
    send_frame({1'b1, addr, 24'd0, data}, 40);
    w = addr - 3'd1;
    if (addr == 3'd0) begin
      pend_col[0] = data[5:0];
    end else if (addr == 3'd1) begin
      pend_col[1] = data[5:0];
    end else begin
      pend_col[{w[1:0], 1'b1}] = data[11:6];  // Texel 1 in the high half
      pend_col[{w[1:0], 1'b0}] = data[5:0];
    end
  endtask

  task automatic check_row(input string test_name, input int v);
    wait_pos(0, v);
    for (int h = 0; h < `RBZ_H_TOTAL; h++) begin
      check_value($sformatf("%s column %0d", test_name, h), h, 32'(o_hpos));
      check_value($sformatf("%s row %0d col %0d", test_name, v, h),
                  32'(expect_pixel(h, v)), 32'(o_rgb));
      if (h < `RBZ_H_TOTAL - 1) begin
        @(negedge clk);
      end
    end
  endtask

  // Whole visible line in one colour
  task automatic check_solid_row(input string test_name, input int v, input logic [5:0] colour);
    wait_pos(0, v);
    for (int h = 0; h < `RBZ_H_TOTAL; h++) begin
      check_value($sformatf("%s row %0d col %0d", test_name, v, h),
                  (h < `RBZ_H_VIEW) ? 32'(colour) : 32'd0, 32'(o_rgb));
      if (h < `RBZ_H_TOTAL - 1) begin
        @(negedge clk);
      end
    end
  endtask

  task automatic reset_timing();
    int low_h;
    int low_v;
    for (int i = 0; i < 15; i++) begin
      @(negedge clk);
      check_value("reset hsync", 1, 32'(o_hsync_n));
      check_value("reset vsync", 1, 32'(o_vsync_n));
      check_value("reset rgb", 0, 32'(o_rgb));
      check_value("reset hpos", 0, 32'(o_hpos));
      check_value("reset vpos", 0, 32'(o_vpos));
    end
    @(posedge clk);
    i_reset <= 1'b0;  // 16 edges in reset
    repeat (4) begin
      @(negedge clk);
      check_value("post reset hsync", 1, 32'(o_hsync_n));
      check_value("post reset vsync", 1, 32'(o_vsync_n));
    end
    low_h = 0;
    wait_pos(0, 5);
    for (int h = 0; h < `RBZ_H_TOTAL; h++) begin
      check_value("line hpos", h, 32'(o_hpos));
      check_value("line hsync", (h >= `RBZ_HS_START && h < `RBZ_HS_END) ? 0 : 1,
                  32'(o_hsync_n));
      low_h += o_hsync_n ? 0 : 1;
      if (h < `RBZ_H_TOTAL - 1) begin
        @(negedge clk);
      end
    end
    check_value("hsync width", `RBZ_HS_END - `RBZ_HS_START, low_h);
    low_v = 0;
    wait_pos(0, 0);
    for (int n = 0; n < `RBZ_H_TOTAL * `RBZ_V_TOTAL; n++) begin
      check_value("frame hpos", n % `RBZ_H_TOTAL, 32'(o_hpos));
      check_value("frame vpos", n / `RBZ_H_TOTAL, 32'(o_vpos));
      check_value("frame vsync", ((n / `RBZ_H_TOTAL) >= `RBZ_VS_START &&
                  (n / `RBZ_H_TOTAL) < `RBZ_VS_END) ? 0 : 1, 32'(o_vsync_n));
      low_v += o_vsync_n ? 0 : 1;
      if (n < `RBZ_H_TOTAL * `RBZ_V_TOTAL - 1) begin
        @(negedge clk);
      end
    end
    check_value("vsync width", (`RBZ_VS_END - `RBZ_VS_START) * `RBZ_H_TOTAL, low_v);
  endtask

  task automatic background_fill();
    check_row("background", 7);
    check_row("background", 300);
    check_row("background", 500);  // Vertical blanking
  endtask

  task automatic textured_walls();
    int w;
    int sz;
    int tu;
    int ta;
    wait_pos(0, 10);
    for (int r = 40; r < 46; r++) begin
      take_bits(2, w);
      take_bits(9, sz);
      take_bits(6, tu);
      take_bits(8, ta);
      write_record(9'(r), 2'((w % 3) + 1), 1'b0, 10'(sz), 6'(tu), 8'(ta));
    end
    wait_pos(0, 0);  // Records fetched from this frame on
    for (int r = 40; r < 46; r++) begin
      check_row("textured", r);
    end
  endtask

  task automatic side_shading();
    wait_pos(0, 10);
    write_record(9'd60, 2'd1, 1'b1, 10'd200, 6'h08, 8'd40);
    write_record(9'd61, 2'd2, 1'b1, 10'd333, 6'h00, 8'd255);
    write_record(9'd62, 2'd3, 1'b1, 10'd17, 6'h2a, 8'd3);
    write_record(9'd63, 2'd2, 1'b0, 10'd700, 6'h08, 8'd0);  // Wider than the view
    write_record(9'd64, 2'd1, 1'b1, 10'd1023, 6'h00, 8'd90);
    wait_pos(0, 0);
    check_row("shading", 60);
    check_row("shading", 61);
    check_row("shading", 62);
    check_solid_row("clamp", 63, 6'b001100);  // Wall 2 texel 1 everywhere
    check_row("clamp", 64);
  endtask

  task automatic deferred_style();
    wait_pos(0, 100);
    write_style(3'd0, 12'h007);
    check_row("style old frame", 200);  // Old bg_left until frame end
    check_row("style old frame", 479);
    check_row("style new frame", 0);
    check_row("style new frame", 200);
  endtask

  task automatic malformed_frames();
    wait_pos(0, 10);
    // Last 40 bits shifted in are a full record for row 90
    send_frame(record_word(9'd90, 2'd2, 1'b0, 10'd400, 6'd9, 8'd33) >> 1, 41);
    // Together with the 0 left in the shifter this is a full record for row 45
    send_frame(record_word(9'd45, 2'd3, 1'b1, 10'd150, 6'd5, 8'd7) << 1, 39);
    write_record(9'd91, 2'd1, 1'b0, 10'd100, 6'd0, 8'd64);  // Port still accepts 40 bits
    wait_pos(0, 0);
    check_row("short frame", 45);
    check_row("long frame", 90);
    check_row("after bad frames", 91);
  endtask

  initial begin
    i_reset <= 1'b1;
    i_sclk  <= 1'b0;
    i_mosi  <= 1'b0;
    i_ss_n  <= 1'b1;  // Deselected
    lfsr_q = 16'd88;
    m_wall = '0;
    m_side = '0;
    m_size = '0;
    m_texu = '0;
    m_texa = '0;
    pend_col[0] = 6'b101010;
    pend_col[1] = 6'b010101;
    pend_col[2] = 6'b100000;  // Wall 1 texel 0
    pend_col[3] = 6'b110000;
    pend_col[4] = 6'b001000;
    pend_col[5] = 6'b001100;
    pend_col[6] = 6'b000010;
    pend_col[7] = 6'b000011;
    reset_timing();
    background_fill();
    textured_walls();
    side_shading();
    deferred_style();
    malformed_frames();
    $display(">>> PASS");
    $finish;
  end
endmodule

// ==== hdl/raycast_top.sv ====
`timescale 1ns/1ps

module raycast_top (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_sclk,   // Host SPI, mode 0
  input  logic       i_mosi,
  input  logic       i_ss_n,
  output logic       o_hsync_n,
  output logic       o_vsync_n,
  output logic [5:0] o_rgb,
  output logic [9:0] o_hpos,   // Aligned with o_rgb
  output logic [9:0] o_vpos
);
  logic                rec_we;
  wall_pkg::row_t      rec_row;
  wall_pkg::wall_rec_t rec;
  wall_pkg::style_t    style;
  video_pkg::pos_t     hpos;
  video_pkg::pos_t     vpos;
  logic                hsync;
  logic                vsync;
  logic                visible;
  logic                line_end;
  logic                frame_end;
  logic                hit;
  video_pkg::rgb_t     wall_rgb;

  wall_if u_wall ();  // Current row record

  host_port u_host (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_sclk      (i_sclk),
    .i_mosi      (i_mosi),
    .i_ss_n      (i_ss_n),
    .i_frame_end (frame_end),
    .o_rec_we    (rec_we),
    .o_rec_row   (rec_row),
    .o_rec       (rec),
    .o_style     (style)
  );

  vga_sync u_sync (
    .clk         (clk),
    .i_reset     (i_reset),
    .o_hpos      (hpos),
    .o_vpos      (vpos),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_visible   (visible),
    .o_line_end  (line_end),
    .o_frame_end (frame_end)
  );

  row_table u_table (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_rec_we   (rec_we),
    .i_rec_row  (rec_row),
    .i_rec      (rec),
    .i_line_end (line_end),
    .i_vpos     (vpos),
    .w          (u_wall)
  );

  row_render u_render (
    .clk     (clk),
    .i_reset (i_reset),
    .i_hpos  (hpos),
    .i_style (style),
    .w       (u_wall),
    .o_hit   (hit),
    .o_rgb   (wall_rgb)
  );

  pixel_out u_out (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_hpos     (hpos),
    .i_vpos     (vpos),
    .i_hsync    (hsync),
    .i_vsync    (vsync),
    .i_visible  (visible),
    .i_hit      (hit),
    .i_wall_rgb (wall_rgb),
    .i_style    (style),
    .o_hsync_n  (o_hsync_n),
    .o_vsync_n  (o_vsync_n),
    .o_rgb      (o_rgb),
    .o_hpos     (o_hpos),
    .o_vpos     (o_vpos)
  );
endmodule

// ==== hdl/pixel_out.sv ====
`timescale 1ns/1ps
`include "rbz_config.svh"

module pixel_out (
  input  logic             clk,
  input  logic             i_reset,
  input  video_pkg::pos_t  i_hpos,
  input  video_pkg::pos_t  i_vpos,
  input  logic             i_hsync,
  input  logic             i_vsync,
  input  logic             i_visible,
  input  logic             i_hit,
  input  video_pkg::rgb_t  i_wall_rgb,
  input  wall_pkg::style_t i_style,
  output logic             o_hsync_n,
  output logic             o_vsync_n,
  output video_pkg::rgb_t  o_rgb,
  output video_pkg::pos_t  o_hpos,
  output video_pkg::pos_t  o_vpos
);
  video_pkg::rgb_t bg_rgb;
  video_pkg::rgb_t pix_rgb;

  // Left and right halves of the rotated screen
  assign bg_rgb  = (i_hpos < `RBZ_HALF_SIZE) ? i_style.bg_left : i_style.bg_right;
  assign pix_rgb = !i_visible ? '0 :   // Black in blanking
                   i_hit      ? i_wall_rgb : bg_rgb;

  // One stage for everything, keeps colour, syncs and positions aligned
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_hsync_n <= 1'b1;
      o_vsync_n <= 1'b1;
      o_rgb     <= '0;
      o_hpos    <= '0;
      o_vpos    <= '0;
    end else begin
      o_hsync_n <= ~i_hsync;
      o_vsync_n <= ~i_vsync;
      o_rgb     <= pix_rgb;
      o_hpos    <= i_hpos;
      o_vpos    <= i_vpos;
    end
  end
endmodule

// ==== hdl/row_render.sv ====
`timescale 1ns/1ps
`include "rbz_config.svh"

module row_render (
  input  logic             clk,
  input  logic             i_reset,
  input  video_pkg::pos_t  i_hpos,
  input  wall_pkg::style_t i_style,
  wall_if.render_side      w,
  output logic             o_hit,
  output video_pkg::rgb_t  o_rgb
);
  video_pkg::pos_t half;      // size/2, rounded down
  video_pkg::pos_t span_lo;   // First wall column
  logic [10:0]     span_sum;  // Unclamped end, may pass 1023
  logic [10:0]     span_hi;   // One past the last wall column
  logic            in_span;
  logic [13:0]     tex_acc;   // 8 fractional bits
  logic [5:0]      texv;
  logic            texel;
  logic [1:0]      pal_idx;
  video_pkg::rgb_t base_rgb;

  assign half     = {1'b0, w.size[9:1]};
  assign span_lo  = (half >= `RBZ_HALF_SIZE) ? '0 :
                    video_pkg::pos_t'(`RBZ_HALF_SIZE) - half;  // Clamp at column 0
  assign span_sum = {1'b0, span_lo} + {1'b0, w.size};
  assign span_hi  = (span_sum > `RBZ_H_VIEW) ? 11'(`RBZ_H_VIEW) : span_sum;
  assign in_span  = (i_hpos >= span_lo) && ({1'b0, i_hpos} < span_hi);
  assign o_hit    = (w.wall != 2'd0) && in_span;

  // Zero outside the span, so each line starts the texture at v=0
  always_ff @(posedge clk) begin
    if (i_reset || !in_span) begin
      tex_acc <= '0;
    end else begin
      tex_acc <= tex_acc + {6'd0, w.texa};
    end
  end

  assign texv  = tex_acc[13:8];       // Value before this pixel's step
  assign texel = w.texu[3] ^ texv[3];  // 8x8 checker

  assign pal_idx  = (w.wall == 2'd0) ? 2'd0 : w.wall - 2'd1;
  assign base_rgb = i_style.pal[pal_idx][texel];
  assign o_rgb    = w.side ? (base_rgb & 6'b10_10_10) : base_rgb;  // Side 1 darker
endmodule

// ==== hdl/row_table.sv ====
`timescale 1ns/1ps
`include "rbz_config.svh"

module row_table (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_rec_we,
  input  wall_pkg::row_t      i_rec_row,
  input  wall_pkg::wall_rec_t i_rec,
  input  logic                i_line_end,
  input  video_pkg::pos_t     i_vpos,
  wall_if.table_side          w
);
  wall_pkg::wall_rec_t    mem [0:`RBZ_V_VIEW-1];  // One record per visible row
  logic [`RBZ_V_VIEW-1:0] row_vld;                // Row written since reset
  wall_pkg::wall_rec_t    cur;                    // Record for the line being scanned
  video_pkg::pos_t        next_row;

  // Row that the coming line will show
  assign next_row = (i_vpos == video_pkg::pos_t'(`RBZ_V_TOTAL - 1)) ? '0 : i_vpos + 10'd1;

  always_ff @(posedge clk) begin
    if (i_rec_we && i_rec_row < `RBZ_V_VIEW) begin
      mem[i_rec_row] <= i_rec;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      row_vld <= '0;
    end else if (i_rec_we && i_rec_row < `RBZ_V_VIEW) begin
      row_vld[i_rec_row] <= 1'b1;
    end
  end

  // Fetch once per line, at line end
  always_ff @(posedge clk) begin
    if (i_reset) begin
      cur <= '0;
    end else if (i_line_end) begin
      if (next_row < `RBZ_V_VIEW && row_vld[next_row[8:0]]) begin
        cur <= mem[next_row[8:0]];
      end else begin
        cur <= '0;  // Blanking or unwritten row, no wall
      end
    end
  end

  assign w.wall = cur.wall;
  assign w.side = cur.side;
  assign w.size = cur.size;
  assign w.texu = cur.texu;
  assign w.texa = cur.texa;
endmodule

// ==== hdl/vga_sync.sv ====
`timescale 1ns/1ps
`include "rbz_config.svh"

module vga_sync (
  input  logic            clk,
  input  logic            i_reset,
  output video_pkg::pos_t o_hpos,
  output video_pkg::pos_t o_vpos,
  output logic            o_hsync,     // Active high here, inverted at the output stage
  output logic            o_vsync,
  output logic            o_visible,
  output logic            o_line_end,  // hpos 799
  output logic            o_frame_end  // hpos 799 on the last visible line
);
  logic h_last;
  logic v_last;

  assign h_last = (o_hpos == video_pkg::pos_t'(`RBZ_H_TOTAL - 1));
  assign v_last = (o_vpos == video_pkg::pos_t'(`RBZ_V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else if (h_last) begin
      o_hpos <= '0;
      o_vpos <= v_last ? '0 : o_vpos + 10'd1;  // Wrap after line 524
    end else begin
      o_hpos <= o_hpos + 10'd1;
    end
  end

  assign o_hsync     = (o_hpos >= `RBZ_HS_START) && (o_hpos < `RBZ_HS_END);
  assign o_vsync     = (o_vpos >= `RBZ_VS_START) && (o_vpos < `RBZ_VS_END);
  assign o_visible   = (o_hpos < `RBZ_H_VIEW) && (o_vpos < `RBZ_V_VIEW);
  assign o_line_end  = h_last;
  assign o_frame_end = h_last && (o_vpos == video_pkg::pos_t'(`RBZ_V_VIEW - 1));
endmodule

// ==== hdl/host_port.sv ====
`timescale 1ns/1ps
`include "rbz_config.svh"

module host_port (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_sclk,
  input  logic                i_mosi,
  input  logic                i_ss_n,
  input  logic                i_frame_end,  // Last pixel of the visible frame
  output logic                o_rec_we,
  output wall_pkg::row_t      o_rec_row,
  output wall_pkg::wall_rec_t o_rec,
  output wall_pkg::style_t    o_style
);
  logic [1:0]               sclk_sync;  // Two-flop synchronisers
  logic [1:0]               mosi_sync;
  logic [1:0]               ss_sync;
  logic                     sclk_d;
  logic                     ss_d;
  logic                     sclk_rise;
  logic                     ss_rise;    // End of frame
  logic [`RBZ_SPI_BITS-1:0] shreg;
  logic [5:0]               bit_cnt;    // Saturates, long frames never alias to 40
  logic                     word_vld;
  wall_pkg::host_word_u     word_q;     // Held until the next frame closes
  logic                     rec_stb;
  logic [4:0]               reg_sel;    // One-hot register address
  wall_pkg::style_t         pend;       // Written now, shown next frame

  function automatic wall_pkg::style_t style_default();
    wall_pkg::style_t s;
    s.bg_left   = 6'b10_10_10;
    s.bg_right  = 6'b01_01_01;
    s.pal[0][1] = 6'b11_00_00;  // Wall 1, reds
    s.pal[0][0] = 6'b10_00_00;
    s.pal[1][1] = 6'b00_11_00;  // Wall 2, greens
    s.pal[1][0] = 6'b00_10_00;
    s.pal[2][1] = 6'b00_00_11;  // Wall 3, blues
    s.pal[2][0] = 6'b00_00_10;
    return s;
  endfunction

  assign sclk_rise = sclk_sync[1] & ~sclk_d;
  assign ss_rise   = ss_sync[1] & ~ss_d;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      ss_sync   <= 2'b11;  // Idle, deselected
      sclk_d    <= 1'b0;
      ss_d      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[0], i_sclk};
      mosi_sync <= {mosi_sync[0], i_mosi};
      ss_sync   <= {ss_sync[0], i_ss_n};
      sclk_d    <= sclk_sync[1];
      ss_d      <= ss_sync[1];
    end
  end

  // Mode 0, MSB first
  always_ff @(posedge clk) begin
    if (sclk_rise && !ss_sync[1]) begin
      shreg <= {shreg[`RBZ_SPI_BITS-2:0], mosi_sync[1]};
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset || ss_sync[1]) begin
      bit_cnt <= '0;  // Cleared while deselected
    end else if (sclk_rise && bit_cnt != 6'd63) begin
      bit_cnt <= bit_cnt + 6'd1;
    end
  end

  // Stage 1, close the frame and check its length
  always_ff @(posedge clk) begin
    if (i_reset) begin
      word_vld <= 1'b0;
    end else begin
      word_vld <= ss_rise && (bit_cnt == `RBZ_SPI_BITS);
    end
  end

  always_ff @(posedge clk) begin
    if (ss_rise) begin
      word_q <= shreg;
    end
  end

  // Stage 2, split by kind and decode the address
  always_ff @(posedge clk) begin
    if (i_reset) begin
      rec_stb <= 1'b0;
      reg_sel <= '0;
    end else begin
      rec_stb <= word_vld && !word_q.rec.kind;
      reg_sel <= '0;
      if (word_vld && word_q.cfg.kind && word_q.cfg.addr <= 3'd4) begin
        reg_sel[word_q.cfg.addr] <= 1'b1;  // Addresses 5..7 are dropped
      end
    end
  end

  // Stage 3, record strobe out
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_rec_we <= 1'b0;
    end else begin
      o_rec_we <= rec_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (rec_stb) begin
      o_rec_row <= word_q.rec.row;
      o_rec     <= word_q.rec.rec;
    end
  end

  // Stage 3, pending style write, and the frame-end swap
  always_ff @(posedge clk) begin
    if (i_reset) begin
      pend    <= style_default();
      o_style <= style_default();
    end else begin
      if (reg_sel[0]) pend.bg_left  <= word_q.cfg.data[5:0];
      if (reg_sel[1]) pend.bg_right <= word_q.cfg.data[5:0];
      for (int i = 0; i < 3; i++) begin
        if (reg_sel[i+2]) pend.pal[i] <= word_q.cfg.data;  // Both texels at once
      end
      if (i_frame_end) begin
        o_style <= pend;  // Colours only change between frames
      end
    end
  end
endmodule

// ==== hdl/wall_if.sv ====
`timescale 1ns/1ps

// Record of the row being scanned, table to renderer
interface wall_if;
  logic [1:0] wall;
  logic       side;
  logic [9:0] size;
  logic [5:0] texu;
  logic [7:0] texa;

  modport table_side (
    output wall, side, size, texu, texa
  );

  modport render_side (
    input wall, side, size, texu, texa
  );
endinterface

// ==== hdl/wall_pkg.sv ====
// Wall records, style set and host word layout

package wall_pkg;

  typedef logic [8:0] row_t;  // Screen row, one ray per row

  // Result of one ray, supplied by the host
  typedef struct packed {
    logic [1:0] wall;  // 0 means no wall on this row
    logic       side;  // 1 selects the shaded face
    logic [9:0] size;  // Span length in pixels
    logic [5:0] texu;  // Texture column
    logic [7:0] texa;  // Texture step, 1/256 texel per pixel
  } wall_rec_t;

  // Colours in use for one frame
  typedef struct packed {
    video_pkg::rgb_t             bg_left;
    video_pkg::rgb_t             bg_right;
    video_pkg::rgb_t [2:0][1:0]  pal;  // [wall-1][texel]
  } style_t;

  // Record view of a host word, 3 pad bits fill the frame
  typedef struct packed {
    logic      kind;  // 0 here
    row_t      row;
    wall_rec_t rec;
    logic [2:0] pad;
  } host_rec_t;

  // Register view of a host word
  typedef struct packed {
    logic        kind;  // 1 here
    logic [2:0]  addr;  // 0 bg_left, 1 bg_right, 2..4 palette of walls 1..3
    logic [23:0] pad;
    logic [11:0] data;  // Palette: texel 1 high, texel 0 low
  } host_reg_t;

  typedef union packed {
    host_rec_t rec;
    host_reg_t cfg;
  } host_word_u;

endpackage

// ==== hdl/video_pkg.sv ====
// Types shared by the timing and pixel path

package video_pkg;

  // Pixel or line coordinate, covers the 800x525 total
  typedef logic [9:0] pos_t;

  // 2 bits per channel, layout {r, g, b} with red in the top bits
  typedef logic [5:0] rgb_t;

endpackage

// ==== hdl/rbz_config.svh ====
`ifndef RBZ_CONFIG_SVH
`define RBZ_CONFIG_SVH

// Horizontal timing in pixels, sync covers start up to end-1
`define RBZ_H_VIEW    640
`define RBZ_H_TOTAL   800
`define RBZ_HS_START  656
`define RBZ_HS_END    752

// Vertical timing in lines
`define RBZ_V_VIEW    480
`define RBZ_V_TOTAL   525
`define RBZ_VS_START  490
`define RBZ_VS_END    492

`define RBZ_HALF_SIZE 320  // Centre column, walls are centred here
`define RBZ_SPI_BITS  40   // Exact length of a valid host frame

`endif
